// ==== rtl/board_defines.svh ====
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

// ----------------------------------------
// Board
// ----------------------------------------
`define CLK_MHZ          50   // Kit oscillator

// ----------------------------------------
// I2S microphone link
// ----------------------------------------
`define SAMPLE_W         24   // Signed sample, MSB first
`define SCK_DIV          4    // clk cycles per sck period, even
`define SLOTS_PER_FRAME  64   // sck periods per ws frame

// ----------------------------------------
// Buffer and display
// ----------------------------------------
`define FIFO_DEPTH       8    // Power of two only
`define W_LED            16
`define W_DIGIT          6    // One nibble per digit
`define SCAN_DIV         16   // clk cycles per lit digit
`define LED_SHIFT        7    // Magnitude bit for the first LED

`endif

// ==== rtl/board_pkg.sv ====
`include "board_defines.svh"

package board_pkg;

    // ----------------------------------------
    // Wishbone classic, no err or rty
    // ----------------------------------------

    // Master side of a link
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;  // High for the receiver, low for the display
        logic [`SAMPLE_W-1:0] dat; // Write data
    } wb_req_t;

    // Slave side of a link
    typedef struct packed {
        logic                 ack; // Single cycle
        logic [`SAMPLE_W-1:0] dat; // Read data, valid with ack
    } wb_rsp_t;

    // ----------------------------------------
    // FSM states
    // ----------------------------------------

    // I2S receiver
    typedef enum logic [1:0] {
        idle_wait_ws, // Until ws drops for the left slot
        shift_bits,   // Left slot bits coming in
        write_req     // Sample waiting for FIFO ack
    } rx_state_e;

    // Level display
    typedef enum logic {
        read_req, // Read cycle outstanding
        update    // Refresh LEDs and digits
    } disp_state_e;

endpackage

// ==== rtl/inmp441_mic_i2s_receiver.sv ====
`timescale 1ns/1ps
`include "board_defines.svh"

module inmp441_mic_i2s_receiver (
    input  logic                clk,
    input  logic                reset,
    output logic                sck,
    output logic                ws,
    input  logic                sd,
    output board_pkg::wb_req_t  wb_out,
    input  board_pkg::wb_rsp_t  wb_in
);

    localparam int div_w  = $clog2(`SCK_DIV);
    localparam int slot_w = $clog2(`SLOTS_PER_FRAME);

    localparam logic [div_w-1:0]  rise_at   = div_w'(`SCK_DIV / 2 - 1);
    localparam logic [div_w-1:0]  fall_at   = div_w'(`SCK_DIV - 1);
    localparam logic [slot_w-1:0] last_slot = slot_w'(`SLOTS_PER_FRAME - 1);
    localparam logic [slot_w-1:0] half_slot = slot_w'(`SLOTS_PER_FRAME / 2);
    localparam logic [slot_w-1:0] done_slot = slot_w'(`SAMPLE_W);

    logic [div_w-1:0]     div_cnt;
    logic [slot_w-1:0]    slot_cnt;
    logic [slot_w-1:0]    slot_nxt;
    logic                 sck_rise;    // sck goes high at this edge
    logic                 sck_fall;    // sck goes low at this edge
    logic                 in_data;     // Slot carries a left sample bit
    logic                 sample_done; // Last bit shifted in at this edge
    logic [`SAMPLE_W-2:0] shift_q;     // All but the final bit
    logic                 req_cyc;
    logic [`SAMPLE_W-1:0] req_dat;

    board_pkg::rx_state_e state;

    // ----------------------------------------
    // Bit clock and word select
    // ----------------------------------------
    assign sck_rise = (div_cnt == rise_at);
    assign sck_fall = (div_cnt == fall_at);
    assign slot_nxt = (slot_cnt == last_slot) ? '0 : slot_cnt + 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt  <= '0;
            sck      <= 1'b0;
            slot_cnt <= last_slot; // First fall opens a left slot
            ws       <= 1'b1;
        end else begin
            div_cnt <= sck_fall ? '0 : div_cnt + 1'b1;
            if (sck_rise)
                sck <= 1'b1;
            if (sck_fall) begin
                sck      <= 1'b0;
                slot_cnt <= slot_nxt;
                ws       <= (slot_nxt >= half_slot); // Low means left
            end
        end
    end

    // ----------------------------------------
    // Deserializer
    // ----------------------------------------
    // One bit of delay after ws falls, so the MSB sits in slot 1
    assign in_data     = (slot_cnt != '0) && (slot_cnt <= done_slot);
    assign sample_done = sck_rise && (slot_cnt == done_slot);

    always_ff @(posedge clk) begin
        if (sck_rise && in_data)
            shift_q <= {shift_q[`SAMPLE_W-3:0], sd}; // MSB first
    end

    // ----------------------------------------
    // Wishbone write master
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= board_pkg::idle_wait_ws;
            req_cyc <= 1'b0;
        end else begin
            case (state)
                board_pkg::idle_wait_ws:
                    if (sck_fall && slot_cnt == last_slot)
                        state <= board_pkg::shift_bits;
                board_pkg::shift_bits:
                    if (sample_done) begin
                        req_cyc <= 1'b1;
                        state   <= board_pkg::write_req;
                    end
                board_pkg::write_req:
                    if (wb_in.ack) begin       // Drop in the cycle after ack
                        req_cyc <= 1'b0;
                        state   <= board_pkg::idle_wait_ws;
                    end
                default:
                    state <= board_pkg::idle_wait_ws;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == board_pkg::shift_bits && sample_done)
            req_dat <= {shift_q, sd};
    end

    assign wb_out = '{cyc: req_cyc, stb: req_cyc, we: 1'b1, dat: req_dat};

    // Request and data stay put until the FIFO answers
    a_stb_held : assert property (@(posedge clk) disable iff (reset)
        wb_out.stb && !wb_in.ack |=> wb_out.stb && $stable(wb_out.dat));

    // A new sample while the last one is still pending gets lost
    a_no_overrun : assert property (@(posedge clk) disable iff (reset)
        sample_done |-> state != board_pkg::write_req)
        else $error("I2S sample dropped, FIFO write still pending");

endmodule

// ==== rtl/sample_fifo.sv ====
`timescale 1ns/1ps
`include "board_defines.svh"

module sample_fifo (
    input  logic               clk,
    input  logic               reset,
    input  board_pkg::wb_req_t wr_req,
    output board_pkg::wb_rsp_t wr_rsp,
    input  board_pkg::wb_req_t rd_req,
    output board_pkg::wb_rsp_t rd_rsp
);

    localparam int depth = `FIFO_DEPTH;
    localparam int aw    = $clog2(`FIFO_DEPTH);

    logic [`SAMPLE_W-1:0] mem [depth];
    logic [aw:0]          wp;    // Extra bit marks the lap
    logic [aw:0]          rp;
    logic [aw:0]          level; // Entries held
    logic                 full;
    logic                 empty;
    logic                 wr_fire;
    logic                 rd_fire;
    logic                 wr_ack;
    logic                 rd_ack;
    logic [`SAMPLE_W-1:0] rd_dat;

    // ----------------------------------------
    // Occupancy
    // ----------------------------------------
    assign level = wp - rp;
    assign empty = (wp == rp);
    assign full  = (wp[aw] != rp[aw]) && (wp[aw-1:0] == rp[aw-1:0]); // Same slot, other lap

    // New request only, held cycle after ack is ignored
    assign wr_fire = wr_req.cyc && wr_req.stb && wr_req.we && !wr_ack && !full;
    assign rd_fire = rd_req.cyc && rd_req.stb && !rd_req.we && !rd_ack && !empty;

    // ----------------------------------------
    // Pointers and acks
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wp     <= '0;
            rp     <= '0;
            wr_ack <= 1'b0;
            rd_ack <= 1'b0;
        end else begin
            wr_ack <= wr_fire; // Wait states while full
            rd_ack <= rd_fire; // Wait states while empty
            if (wr_fire)
                wp <= wp + 1'b1;
            if (rd_fire)
                rp <= rp + 1'b1;
        end
    end

    // Storage and read data
    always_ff @(posedge clk) begin
        if (wr_fire)
            mem[wp[aw-1:0]] <= wr_req.dat;
        if (rd_fire)
            rd_dat <= mem[rp[aw-1:0]];
    end

    assign wr_rsp = '{ack: wr_ack, dat: '0};   // Nothing to return on writes
    assign rd_rsp = '{ack: rd_ack, dat: rd_dat};

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_wr_ack_has_stb : assert property (@(posedge clk) disable iff (reset)
        wr_rsp.ack |-> wr_req.cyc && wr_req.stb);

    a_rd_ack_has_stb : assert property (@(posedge clk) disable iff (reset)
        rd_rsp.ack |-> rd_req.cyc && rd_req.stb);

    // Never past depth, so no write went in while full
    a_no_overflow : assert property (@(posedge clk) disable iff (reset)
        level <= (aw + 1)'(depth));

    // Read data only ever comes from a stored entry
    a_no_underflow : assert property (@(posedge clk) disable iff (reset)
        rd_rsp.ack |-> $past(level) != '0);

endmodule

// ==== rtl/level_display.sv ====
`timescale 1ns/1ps
`include "board_defines.svh"

module level_display (
    input  logic                  clk,
    input  logic                  reset,
    output board_pkg::wb_req_t    wb_out,
    input  board_pkg::wb_rsp_t    wb_in,
    output logic [`W_LED-1:0]     led,
    output logic [7:0]            abcdefgh,
    output logic [`W_DIGIT-1:0]   digit      // Active high here
);

    localparam int scan_w = $clog2(`SCAN_DIV);
    localparam int idx_w  = $clog2(`W_DIGIT);

    localparam logic [`SAMPLE_W-1:0] s_min = {1'b1, {(`SAMPLE_W - 1){1'b0}}};
    localparam logic [`SAMPLE_W-1:0] s_max = {1'b0, {(`SAMPLE_W - 1){1'b1}}};

    board_pkg::disp_state_e state;

    logic                 req_cyc;
    logic [`SAMPLE_W-1:0] sample_q;    // Last acked sample
    logic [`SAMPLE_W-1:0] shown_q;     // Value on the digits
    logic                 shown_valid; // Blank until first sample
    logic [scan_w-1:0]    scan_cnt;
    logic [idx_w-1:0]     digit_idx;

    // Bar length from the highest magnitude bit
    function automatic logic [`W_LED-1:0] bar_leds(input logic [`SAMPLE_W-1:0] s);
        logic [`SAMPLE_W-1:0] mag;
        int                   msb_idx;
        int                   count;
        logic [`W_LED-1:0]    bar;
        if (s == s_min)
            mag = s_max;             // Saturate, -min does not fit
        else if (s[`SAMPLE_W-1])
            mag = -s;
        else
            mag = s;
        msb_idx = -1;                // Zero magnitude
        for (int i = 0; i < `SAMPLE_W; i++)
            if (mag[i])
                msb_idx = i;
        count = msb_idx - `LED_SHIFT + 1;
        if (count < 0)
            count = 0;
        if (count > `W_LED)
            count = `W_LED;
        for (int i = 0; i < `W_LED; i++)
            bar[i] = (i < count);    // Fill from bit 0 up
        return bar;
    endfunction

    // Segments abcdefgh, a is bit 7, h the decimal point stays off
    //   0 fc  1 60  2 da  3 f2  4 66  5 b6  6 be  7 e0
    //   8 fe  9 f6  A ee  b 3e  C 9c  d 7a  E 9e  F 8e
    function automatic logic [7:0] hex_seg(input logic [3:0] nib);
        case (nib)
            4'h0: return 8'b1111_1100;
            4'h1: return 8'b0110_0000;
            4'h2: return 8'b1101_1010;
            4'h3: return 8'b1111_0010;
            4'h4: return 8'b0110_0110;
            4'h5: return 8'b1011_0110;
            4'h6: return 8'b1011_1110;
            4'h7: return 8'b1110_0000;
            4'h8: return 8'b1111_1110;
            4'h9: return 8'b1111_0110;
            4'ha: return 8'b1110_1110;
            4'hb: return 8'b0011_1110;
            4'hc: return 8'b1001_1100;
            4'hd: return 8'b0111_1010;
            4'he: return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

    // ----------------------------------------
    // Wishbone read master
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= board_pkg::read_req;
            req_cyc     <= 1'b0;
            led         <= '0;
            shown_valid <= 1'b0;
        end else begin
            case (state)
                board_pkg::read_req:
                    if (wb_in.ack) begin
                        req_cyc <= 1'b0;
                        state   <= board_pkg::update;
                    end else begin
                        req_cyc <= 1'b1; // Waits out an empty FIFO
                    end
                default: begin
                    led         <= bar_leds(sample_q);
                    shown_valid <= 1'b1;
                    req_cyc     <= 1'b1; // Next read straight away
                    state       <= board_pkg::read_req;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wb_in.ack)
            sample_q <= wb_in.dat;
        if (state == board_pkg::update)
            shown_q <= sample_q;
    end

    assign wb_out = '{cyc: req_cyc, stb: req_cyc, we: 1'b0, dat: '0};

    // ----------------------------------------
    // Digit scan, digit 0 is the low nibble
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            scan_cnt  <= '0;
            digit_idx <= '0;
            digit     <= '0;
            abcdefgh  <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
            if (scan_cnt == scan_w'(`SCAN_DIV - 1))
                digit_idx <= (digit_idx == idx_w'(`W_DIGIT - 1)) ? '0 : digit_idx + 1'b1;
            digit    <= shown_valid ? `W_DIGIT'(1) << digit_idx : '0;
            abcdefgh <= shown_valid ? hex_seg(shown_q[4 * digit_idx +: 4]) : '0;
        end
    end

    a_ack_in_read : assert property (@(posedge clk) disable iff (reset)
        wb_in.ack |-> wb_out.stb && state == board_pkg::read_req);

endmodule

// ==== rtl/board_specific_top.sv ====
`timescale 1ns/1ps
`include "board_defines.svh"

module board_specific_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                sd,        // Microphone data
    output logic                sck,
    output logic                ws,
    output logic                lr,        // Channel select pin
    output logic [`W_LED-1:0]   led,
    output logic [7:0]          abcdefgh,
    output logic [`W_DIGIT-1:0] digit_n    // Low lights a digit
);

    // ----------------------------------------
    // Links through the sample FIFO
    // ----------------------------------------
    board_pkg::wb_req_t     mic_req;   // Receiver writes
    board_pkg::wb_rsp_t     mic_rsp;
    board_pkg::wb_req_t     disp_req;  // Display reads
    board_pkg::wb_rsp_t     disp_rsp;
    logic [`W_DIGIT-1:0]    digit;

    assign lr      = 1'b0;     // Left channel only
    assign digit_n = ~digit;   // Board drives digits active low

    inmp441_mic_i2s_receiver i_mic (
        .clk    (clk),
        .reset  (reset),
        .sck    (sck),
        .ws     (ws),
        .sd     (sd),
        .wb_out (mic_req),
        .wb_in  (mic_rsp)
    );

    sample_fifo i_fifo (
        .clk    (clk),
        .reset  (reset),
        .wr_req (mic_req),
        .wr_rsp (mic_rsp),
        .rd_req (disp_req),
        .rd_rsp (disp_rsp)
    );

    level_display i_display (
        .clk      (clk),
        .reset    (reset),
        .wb_out   (disp_req),
        .wb_in    (disp_rsp),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

endmodule

// ==== verif/tb_board_top.sv ====
`timescale 1ns/1ps
`include "board_defines.svh"

module tb_board_top;

    localparam int frame_cycles = `SCK_DIV * `SLOTS_PER_FRAME; // 256 clk per ws frame

    logic                  clk;
    logic                  reset;
    logic                  sd;
    logic                  sck;
    logic                  ws;
    logic                  lr;
    logic [`W_LED-1:0]     led;
    logic [7:0]            abcdefgh;
    logic [`W_DIGIT-1:0]   digit_n;

    logic [`SAMPLE_W-1:0]  samples [$];  // Golden stimulus, file order
    int                    leds_exp [$]; // Lit LED count per sample
    int                    cycle_cnt;
    int                    cycle_limit;

    board_specific_top i_dut (
        .clk      (clk),
        .reset    (reset),
        .sd       (sd),
        .sck      (sck),
        .ws       (ws),
        .lr       (lr),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit_n  (digit_n)
    );

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[FAIL] %s expected %h actual %h", test, expected, actual);
        $display("Simulation FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic abort_run(input string what);
        $display("ERROR: %s", what);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1; // Outputs settled, inputs change here
    endtask

    // Bar from bit 0 upward
    function automatic logic [`W_LED-1:0] led_mask(input int count);
        logic [`W_LED-1:0] m;
        m = '0;
        for (int i = 0; i < count && i < `W_LED; i++)
            m[i] = 1'b1;
        return m;
    endfunction

    // Hex pattern, segment a is bit 7, decimal point h off
    function automatic logic [7:0] seg_pattern(input logic [3:0] nib);
        case (nib)
            4'h0: return 8'hfc;
            4'h1: return 8'h60;
            4'h2: return 8'hda;
            4'h3: return 8'hf2;
            4'h4: return 8'h66;
            4'h5: return 8'hb6;
            4'h6: return 8'hbe;
            4'h7: return 8'he0;
            4'h8: return 8'hfe;
            4'h9: return 8'hf6;
            4'ha: return 8'hee;
            4'hb: return 8'h3e;
            4'hc: return 8'h9c;
            4'hd: return 8'h7a;
            4'he: return 8'h9e;
            default: return 8'h8e;
        endcase
    endfunction

    task automatic load_golden();
        int                   fd;
        int                   n;
        int                   count;
        string                line;
        logic [`SAMPLE_W-1:0] s;
        fd = $fopen("verif/mic_golden.txt", "r");
        if (fd == 0)
            abort_run("cannot open verif/mic_golden.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line[0] != "/") begin // Skip column notes
                n = $sscanf(line, "%h %d", s, count);
                if (n == 2) begin
                    samples.push_back(s);
                    leds_exp.push_back(count);
                end
            end
        end
        $fclose(fd);
        if (samples.size() == 0)
            abort_run("golden file holds no samples");
    endtask

    // Returns right after the edge where ws rises, mid frame
    task automatic wait_ws_rise();
        logic prev;
        logic now_ws;
        now_ws = ws;
        do begin
            prev = now_ws;
            next_cycle();
            now_ws = ws;
        end while (prev || !now_ws);
    endtask

    // ----------------------------------------
    // Clock, watchdog, scan exclusivity
    // ----------------------------------------
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
                abort_run($sformatf("simulation timed out after %0d cycles", cycle_cnt));
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (!reset)
                assert ($onehot0(~digit_n))
                    else abort_run($sformatf("more than one digit lit, digit_n %b", digit_n));
        end
    end

    // ----------------------------------------
    // Microphone model
    // ----------------------------------------
    initial begin
        int                   frame;
        int                   slot;
        logic                 prev_sck;
        logic                 prev_ws;
        logic [`SAMPLE_W-1:0] cur;
        sd       = 1'b0;
        frame    = -1;
        slot     = 0;
        prev_sck = 1'b0;
        prev_ws  = 1'b1;
        cur      = '0;
        forever begin
            next_cycle();
            if (prev_sck && !sck) begin           // Bit clock just fell
                if (prev_ws && !ws) begin         // New left slot
                    frame++;
                    slot = 0;
                    cur  = (frame < samples.size()) ? samples[frame] : '0;
                end else begin
                    slot++;
                end
                // One bit delay after ws, MSB in slot 1
                if (!ws && slot >= 1 && slot <= `SAMPLE_W)
                    sd = cur[`SAMPLE_W - slot];
                else
                    sd = 1'b0;
            end
            prev_sck = sck;
            prev_ws  = ws;
        end
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int                   n;
        int                   d;
        logic [`W_DIGIT-1:0]  seen;
        logic [`SAMPLE_W-1:0] val;
        logic [7:0]           exp_seg;
        reset       = 1'b1;
        cycle_limit = 0;
        load_golden();
        cycle_limit = samples.size() * frame_cycles * 3 + 200;

        repeat (10) begin
            next_cycle();
            assert (led == '0) else report_mismatch("reset led", 32'(0), 32'(led));
            assert (digit_n == '1)
                else report_mismatch("reset digit_n", 32'(6'h3f), 32'(digit_n));
            assert (!sck) else report_mismatch("reset sck", 32'(0), 32'(sck));
            assert (ws) else report_mismatch("reset ws", 32'(1), 32'(ws));
            assert (!lr) else report_mismatch("reset lr", 32'(0), 32'(lr));
        end
        reset = 1'b0;
        next_cycle();
        assert (led == '0) else report_mismatch("post reset led", 32'(0), 32'(led));
        assert (digit_n == '1)
            else report_mismatch("post reset digit_n", 32'(6'h3f), 32'(digit_n));
        assert (!lr) else report_mismatch("post reset lr", 32'(0), 32'(lr));

        for (n = 0; n < samples.size(); n++) begin
            wait_ws_rise();                        // Sample n is on display by now
            val = samples[n];
            assert (led == led_mask(leds_exp[n]))
                else report_mismatch($sformatf("led bar frame %0d", n),
                                     32'(led_mask(leds_exp[n])), 32'(led));
            seen = '0;
            while (ws) begin                       // Right half of the frame
                for (d = 0; d < `W_DIGIT; d++) begin
                    if (!digit_n[d]) begin
                        seen[d] = 1'b1;
                        exp_seg = seg_pattern(val[4 * d +: 4]);
                        assert (abcdefgh == exp_seg)
                            else report_mismatch($sformatf("digit %0d frame %0d", d, n),
                                                 32'(exp_seg), 32'(abcdefgh));
                    end
                end
                next_cycle();
            end
            assert (&seen)
                else abort_run($sformatf("frame %0d, not every digit was lit", n));
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== verif/mic_golden.txt ====
// sample (24-bit hex, left slot)  expected lit LED count (decimal)
// frames go out back to back in this order
000000 0
000001 0
00007f 0
000080 1
0000ff 1
000100 2
001234 6
7fffff 16
ffffff 0
ffff80 1
ffff81 0
800000 16
800001 16
400000 16
200000 15
c00000 16
e00000 15
fedcba 10
0abcde 13
00ffff 9
f0f0f0 13
000400 4
fff000 6
123456 14
543210 16

// ==== build.f ====
+incdir+rtl
rtl/board_pkg.sv
rtl/inmp441_mic_i2s_receiver.sv
rtl/sample_fifo.sv
rtl/level_display.sv
rtl/board_specific_top.sv
verif/tb_board_top.sv

// ==== run_verilator.sh ====
#!/bin/sh
# Build and run the board testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f build.f \
    --top-module tb_board_top \
    -o tb_board_top

./obj_dir/tb_board_top
